/* rtl/obj_pkg.sv */
// sprite subsystem shared definitions
// object entry, line buffer pixel and object table layout
package obj_pkg;

    // one sprite job as handed from the scanner to the drawer
    typedef struct packed {
        logic [8:0] code;
        logic [7:0] xpos;
        logic [3:0] pal;
        logic       hflip;
        logic       vflip;
        // row inside the 16-line sprite, already vflip corrected
        logic [3:0] ysub;
    } obj_entry_t;

    // line buffer pixel, colour 0 is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] color;
    } obj_pxl_t;

    localparam int         OBJ_BYTES   = 4;
    // row scroll area, 2 bytes per 8-line band
    localparam logic [9:0] SCROLL_BASE = 10'h300;
    localparam int         ROM_AW      = 14;

    // entry layout: attr, y, code low, x
    // attr bit 7 vflip, bit 6 hflip, bit 5 code msb, bits 3..0 palette
    localparam logic [9:0] ATTR_BYTE  = 10'd0;
    localparam logic [9:0] Y_BYTE     = 10'd1;
    localparam logic [9:0] CODE_BYTE  = 10'd2;
    localparam logic [9:0] X_BYTE     = 10'd3;
    localparam int         ATTR_VFLIP = 7;
    localparam int         ATTR_HFLIP = 6;
    localparam int         ATTR_CODE8 = 5;

endpackage

/* rtl/obj_draw_if.sv */
// sprite job channel between the table scanner and the drawer
// start is a one-cycle pulse that hands over job
// busy goes high the next clock and holds until the last pixel is written
interface obj_draw_if
    import obj_pkg::*;
();

    logic       start;
    obj_entry_t job;
    logic       busy;

    // scanner side
    modport scan (
        output start,
        output job,
        input  busy
    );

    // drawer side
    modport draw (
        input  start,
        input  job,
        output busy
    );

endinterface

/* rtl/obj_table_ram.sv */
// double object table RAM
// the CPU sees the bank picked by frame, the scanner reads the other one
// both read ports are registered
module obj_table_ram #(
    parameter type dtype = logic [7:0]
) (
    input  logic       clk,
    input  logic       frame,
    // CPU port
    input  logic [9:0] cpu_addr,
    input  dtype       cpu_din,
    input  logic       cpu_we,
    output dtype       cpu_dout,
    // scanner port, read only
    input  logic [9:0] scan_addr,
    output dtype       scan_dout
);

    // two 1 kB banks
    dtype mem [0:1][0:1023];

    logic cpu_bank;
    logic scan_bank;

    // scanner always works on the bank the CPU is not using
    assign cpu_bank  = frame;
    assign scan_bank = ~frame;

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_bank][cpu_addr] <= cpu_din;
        end
        // read before write on the same address
        cpu_dout  <= mem[cpu_bank][cpu_addr];
        scan_dout <= mem[scan_bank][scan_addr];
    end

endmodule

/* rtl/obj_scan.sv */
// per-line object table scanner
// reads the row scroll word for the coming line, then walks NUM_OBJ entries
// and hands every sprite covering the line to the drawer
module obj_scan
    import obj_pkg::*;
#(
    parameter int NUM_OBJ = 24
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       hinit,
    input  logic [8:0] vdump,
    output logic [9:0] scan_addr,
    input  logic [7:0] scan_dout,
    output logic [7:0] hpos,
    output logic       scr_we,
    obj_draw_if.scan   drw
);

    localparam int CW = $clog2(NUM_OBJ + 1);

    typedef enum logic [3:0] {
        S_IDLE, S_SCR_A, S_SCR_B, S_SCR_C, S_SCR_D,
        S_WAIT, S_ATTR, S_Y, S_CODE, S_X, S_START, S_NEXT
    } st_t;

    st_t        st;
    logic [7:0] vnext;
    logic [7:0] vline;
    logic [7:0] ypos;
    logic [7:0] ydiff;
    logic [6:0] scr_lo;
    logic [CW-1:0] obj_cnt;
    logic [9:0] ent_base;
    obj_entry_t job_q;
    logic       start_q;

    // sprites are drawn one line ahead of the display
    assign vnext = vdump[7:0] + 8'd1;
    assign ydiff = vline - ypos;

    assign drw.start = start_q;
    assign drw.job   = job_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st      <= S_IDLE;
            start_q <= 1'b0;
            scr_we  <= 1'b0;
            obj_cnt <= '0;
        end else begin
            start_q <= 1'b0;
            scr_we  <= 1'b0;
            if (hinit) begin
                // restart even if the previous walk did not finish
                vline     <= vnext;
                scan_addr <= SCROLL_BASE + {4'd0, vnext[7:3], 1'b0};
                st        <= S_SCR_A;
            end else begin
                case (st)
                    // RAM latency, first scroll byte in flight
                    S_SCR_A: st <= S_SCR_B;
                    S_SCR_B: begin
                        scr_lo    <= scan_dout[7:1];
                        scan_addr <= scan_addr + 10'd1;
                        st        <= S_SCR_C;
                    end
                    S_SCR_C: st <= S_SCR_D;
                    // only bit 0 of the second byte is used
                    S_SCR_D: begin
                        hpos      <= {scr_lo, scan_dout[0]};
                        scr_we    <= 1'b1;
                        obj_cnt   <= '0;
                        ent_base  <= '0;
                        scan_addr <= ATTR_BYTE;
                        st        <= S_WAIT;
                    end
                    // address stream runs one byte ahead of the data
                    S_WAIT: begin
                        scan_addr <= ent_base + Y_BYTE;
                        st        <= S_ATTR;
                    end
                    S_ATTR: begin
                        job_q.pal     <= scan_dout[3:0];
                        job_q.hflip   <= scan_dout[ATTR_HFLIP];
                        job_q.vflip   <= scan_dout[ATTR_VFLIP];
                        job_q.code[8] <= scan_dout[ATTR_CODE8];
                        scan_addr     <= ent_base + CODE_BYTE;
                        st            <= S_Y;
                    end
                    S_Y: begin
                        ypos      <= scan_dout;
                        scan_addr <= ent_base + X_BYTE;
                        st        <= S_CODE;
                    end
                    S_CODE: begin
                        job_q.code[7:0] <= scan_dout;
                        st              <= S_X;
                    end
                    // zone check, row offset below 16
                    S_X: begin
                        job_q.xpos <= scan_dout;
                        job_q.ysub <= ydiff[3:0] ^ {4{job_q.vflip}};
                        st         <= (ydiff[7:4] == 4'd0) ? S_START : S_NEXT;
                    end
                    // hold here while the drawer is on the previous job
                    S_START: begin
                        if (!drw.busy) begin
                            start_q <= 1'b1;
                            st      <= S_NEXT;
                        end
                    end
                    // also the gap cycle that lets busy rise
                    S_NEXT: begin
                        if (obj_cnt == CW'(NUM_OBJ - 1)) begin
                            st <= S_IDLE;
                        end else begin
                            obj_cnt   <= obj_cnt + 1'b1;
                            ent_base  <= ent_base + 10'(OBJ_BYTES);
                            scan_addr <= ent_base + 10'(OBJ_BYTES) + ATTR_BYTE;
                            st        <= S_WAIT;
                        end
                    end
                    default: st <= S_IDLE;
                endcase
            end
        end
    end

    // a job is never handed over while the drawer is still busy
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst) !(drw.start && drw.busy)
    );

endmodule

/* rtl/obj_draw.sv */
// sprite row drawer
// two four-phase ROM fetches per job, 8 pixels each
// writes non transparent pixels into the line buffer, one per clock
module obj_draw
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    obj_draw_if.draw          drw,
    // graphics ROM
    output logic              rom_req,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ack,
    input  logic [31:0]       rom_data,
    // line buffer write port
    output logic              wr_en,
    output logic [7:0]        wr_addr,
    output obj_pxl_t          wr_pxl
);

    typedef enum logic [1:0] {D_IDLE, D_REQ, D_ACK, D_PIX} st_t;

    st_t        st;
    obj_entry_t job;
    logic       half;
    logic [2:0] col;
    logic [2:0] nib;
    logic [3:0] color;
    logic [31:0] data_q;
    logic       busy_q;

    assign drw.busy = busy_q;

    // hflip mirrors the nibble order inside a half
    assign nib   = col ^ {3{job.hflip}};
    assign color = data_q[{nib, 2'b00} +: 4];

    // half selects the screen half, column is xpos plus 0..15
    assign wr_en   = (st == D_PIX) && (color != 4'd0);
    assign wr_addr = job.xpos + {4'd0, half, col};
    assign wr_pxl  = '{pal: job.pal, color: color};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st      <= D_IDLE;
            busy_q  <= 1'b0;
            rom_req <= 1'b0;
            half    <= 1'b0;
            col     <= 3'd0;
        end else begin
            case (st)
                D_IDLE: begin
                    if (drw.start) begin
                        job    <= drw.job;
                        busy_q <= 1'b1;
                        half   <= 1'b0;
                        st     <= D_REQ;
                    end
                end
                // previous cycle must be fully closed before a new req
                D_REQ: begin
                    if (!rom_ack) begin
                        // word address is code, row, then half
                        // with hflip the right half is fetched first
                        rom_addr <= ROM_AW'({job.code, job.ysub, half ^ job.hflip});
                        rom_req  <= 1'b1;
                        st       <= D_ACK;
                    end
                end
                D_ACK: begin
                    if (rom_ack) begin
                        data_q  <= rom_data;
                        rom_req <= 1'b0;
                        col     <= 3'd0;
                        st      <= D_PIX;
                    end
                end
                D_PIX: begin
                    col <= col + 3'd1;
                    if (col == 3'd7) begin
                        if (half) begin
                            busy_q <= 1'b0;
                            st     <= D_IDLE;
                        end else begin
                            half <= 1'b1;
                            st   <= D_REQ;
                        end
                    end
                end
                default: st <= D_IDLE;
            endcase
        end
    end

    // address held for the whole request phase
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst) rom_req |=> !rom_req || $stable(rom_addr)
    );

    // new request only once the ROM has released ack
    a_req_after_ack: assert property (
        @(posedge clk) disable iff (rst) $rose(rom_req) |-> !$past(rom_ack)
    );

endmodule

/* rtl/obj_line_buf.sv */
// double line buffer
// one half is drawn while the other plays back at pixel rate
// every location is cleared as soon as it has been read
module obj_line_buf
    import obj_pkg::*;
#(
    parameter logic [7:0] HOFFSET = 8'd0
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       hinit,
    // drawer side
    input  logic       wr_en,
    input  logic [7:0] wr_addr,
    input  obj_pxl_t   wr_pxl,
    // video side
    input  logic       pxl_cen,
    input  logic [8:0] hdump,
    output obj_pxl_t   pxl
);

    obj_pxl_t   mem [0:1][0:255];
    logic       bank;
    logic [7:0] rd_addr;

    // drawn x to displayed x
    assign rd_addr = hdump[7:0] - HOFFSET;

    // bank is the draw half, ~bank the playback half
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[bank][wr_addr] <= wr_pxl;
        end
        if (pxl_cen) begin
            mem[~bank][rd_addr] <= '0;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
            pxl  <= '0;
        end else begin
            // halves swap at the start of each line
            if (hinit) begin
                bank <= ~bank;
            end
            if (pxl_cen) begin
                pxl <= mem[~bank][rd_addr];
            end
        end
    end

endmodule

/* rtl/obj_top.sv */
// sprite subsystem top level
// object table RAM, scanner, drawer and line buffer
module obj_top
    import obj_pkg::*;
#(
    parameter int         NUM_OBJ = 24,
    parameter logic [7:0] HOFFSET = 8'd0
) (
    input  logic              clk,
    input  logic              rst,
    // CPU
    input  logic [9:0]        cpu_addr,
    input  logic [7:0]        cpu_dout,
    input  logic              obj_cs,
    input  logic              cpu_rnw,
    input  logic              frame,
    output logic [7:0]        obj_dout,
    // video timing
    input  logic              hinit,
    input  logic [8:0]        vdump,
    input  logic [8:0]        hdump,
    input  logic              pxl_cen,
    // row scroll
    output logic [7:0]        hpos,
    output logic              scr_we,
    // graphics ROM
    output logic              rom_req,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ack,
    input  logic [31:0]       rom_data,
    output obj_pxl_t          pxl
);

    logic       cpu_we;
    logic [9:0] scan_addr;
    logic [7:0] scan_dout;
    logic       wr_en;
    logic [7:0] wr_addr;
    obj_pxl_t   wr_pxl;

    obj_draw_if u_drw_if ();

    assign cpu_we = obj_cs & ~cpu_rnw;

    obj_table_ram #(
        .dtype      ( logic [7:0] )
    ) u_ram (
        .clk        ( clk         ),
        .frame      ( frame       ),
        .cpu_addr   ( cpu_addr    ),
        .cpu_din    ( cpu_dout    ),
        .cpu_we     ( cpu_we      ),
        .cpu_dout   ( obj_dout    ),
        .scan_addr  ( scan_addr   ),
        .scan_dout  ( scan_dout   )
    );

    obj_scan #(
        .NUM_OBJ    ( NUM_OBJ     )
    ) u_scan (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .hinit      ( hinit       ),
        .vdump      ( vdump       ),
        .scan_addr  ( scan_addr   ),
        .scan_dout  ( scan_dout   ),
        .hpos       ( hpos        ),
        .scr_we     ( scr_we      ),
        .drw        ( u_drw_if    )
    );

    obj_draw u_draw (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .drw        ( u_drw_if    ),
        .rom_req    ( rom_req     ),
        .rom_addr   ( rom_addr    ),
        .rom_ack    ( rom_ack     ),
        .rom_data   ( rom_data    ),
        .wr_en      ( wr_en       ),
        .wr_addr    ( wr_addr     ),
        .wr_pxl     ( wr_pxl      )
    );

    obj_line_buf #(
        .HOFFSET    ( HOFFSET     )
    ) u_buf (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .hinit      ( hinit       ),
        .wr_en      ( wr_en       ),
        .wr_addr    ( wr_addr     ),
        .wr_pxl     ( wr_pxl      ),
        .pxl_cen    ( pxl_cen     ),
        .hdump      ( hdump       ),
        .pxl        ( pxl         )
    );

endmodule

/* verification/obj_rom_model.sv */
// graphics ROM model with a four-phase req/ack port
// nibble p of word a is (a + p) mod 15 + 1, code 9'h1aa has transparent even pixels
// ack delay of 0..7 clocks from an xorshift sequence
module obj_rom_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic [13:0] addr,
    output logic        ack,
    output logic [31:0] data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] rnd;
    logic [2:0]  wait_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rom_word(input logic [13:0] a);
        logic [31:0] w;
        int          n;
        w = '0;
        for (int p = 0; p < 8; p++) begin
            n = (int'(a) + p) % 15 + 1;
            // marked code, checkerboard of transparent pixels
            if (a[13:5] == 9'h1aa && p % 2 == 0) begin
                n = 0;
            end
            w[p*4 +: 4] = 4'(n);
        end
        return w;
    endfunction

    initial begin
        ack      = 1'b0;
        data     = '0;
        rnd      = 32'h896;
        wait_cnt = 3'd0;
    end

    // responds a small delay after the edge, like the rest of the stimulus
    always @(posedge clk) begin
        #1;
        if (rst) begin
            ack      = 1'b0;
            wait_cnt = 3'd0;
        end else if (req && !ack) begin
            if (wait_cnt == 3'd0) begin
                ack      = 1'b1;
                data     = rom_word(addr);
                rnd      = xorshift32(rnd);
                wait_cnt = rnd[2:0];
            end else begin
                wait_cnt = wait_cnt - 3'd1;
            end
        end else if (!req && ack) begin
            // requester released, close the cycle
            ack = 1'b0;
        end
    end

endmodule

/* verification/obj_tb.sv */
// sprite subsystem testbench
// fills the object table, runs a small video timing generator and checks
// row scroll, line buffer pixels and the ROM handshake against a reference
module obj_tb
    import obj_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [7:0] HOFF    = 8'd2;
    localparam int         NSPR    = 5;
    localparam int         TIMEOUT = 40 * 320;

    logic        clk;
    logic        rst;
    logic [9:0]  cpu_addr;
    logic [7:0]  cpu_wdata;
    logic        obj_cs;
    logic        cpu_rnw;
    logic        frame;
    logic [7:0]  obj_dout;
    logic        hinit;
    logic [8:0]  vdump;
    logic [8:0]  hdump;
    logic        pxl_cen;
    logic [7:0]  hpos;
    logic        scr_we;
    logic        rom_req;
    logic [13:0] rom_addr;
    logic        rom_ack;
    logic [31:0] rom_data;
    obj_pxl_t    pxl;

    int          errors;
    int          checks;
    int          cycles;
    int          scr_cnt;
    logic        video_on;
    logic        started;
    logic [8:0]  hcnt;
    logic        chk_pxl;
    logic [7:0]  chk_x;
    logic [7:0]  chk_v;
    logic [7:0]  spr_attr [0:NSPR-1];
    logic [7:0]  spr_y    [0:NSPR-1];
    logic [7:0]  spr_code [0:NSPR-1];
    logic [7:0]  spr_x    [0:NSPR-1];

    obj_top #(
        .NUM_OBJ  ( 24        ),
        .HOFFSET  ( HOFF      )
    ) DUT (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .cpu_addr ( cpu_addr  ),
        .cpu_dout ( cpu_wdata ),
        .obj_cs   ( obj_cs    ),
        .cpu_rnw  ( cpu_rnw   ),
        .frame    ( frame     ),
        .obj_dout ( obj_dout  ),
        .hinit    ( hinit     ),
        .vdump    ( vdump     ),
        .hdump    ( hdump     ),
        .pxl_cen  ( pxl_cen   ),
        .hpos     ( hpos      ),
        .scr_we   ( scr_we    ),
        .rom_req  ( rom_req   ),
        .rom_addr ( rom_addr  ),
        .rom_ack  ( rom_ack   ),
        .rom_data ( rom_data  ),
        .pxl      ( pxl       )
    );

    obj_rom_model u_rom (
        .clk  ( clk      ),
        .rst  ( rst      ),
        .req  ( rom_req  ),
        .addr ( rom_addr ),
        .ack  ( rom_ack  ),
        .data ( rom_data )
    );

    always #4 clk = ~clk;

    // scroll bytes for band b
    function automatic logic [7:0] scroll_byte(input int b, input int idx);
        return (idx == 0) ? 8'(b * 8'h29 + 8'h17) : 8'(b ^ 1);
    endfunction

    // expected hpos for the line after v
    function automatic logic [7:0] scroll_hpos(input logic [8:0] v);
        logic [7:0] vn;
        logic [7:0] b0;
        logic [7:0] b1;
        vn = v[7:0] + 8'd1;
        b0 = scroll_byte(int'(vn[7:3]), 0);
        b1 = scroll_byte(int'(vn[7:3]), 1);
        return {b0[7:1], b1[0]};
    endfunction

    function automatic logic [3:0] rom_nibble(input logic [13:0] a, input logic [2:0] p);
        if (a[13:5] == 9'h1aa && !p[0]) begin
            return 4'd0;
        end
        return 4'((int'(a) + int'(p)) % 15 + 1);
    endfunction

    // reference pixel at buffer column x for line v, later entries on top
    function automatic logic [7:0] expect_pxl(input logic [7:0] v, input logic [7:0] x);
        logic [7:0]  res;
        logic [7:0]  d;
        logic [7:0]  c;
        logic [3:0]  row;
        logic [3:0]  s;
        logic [3:0]  n;
        logic [13:0] a;
        res = 8'd0;
        for (int i = 0; i < NSPR; i++) begin
            d = v - spr_y[i];
            c = x - spr_x[i];
            if (d < 8'd16 && c < 8'd16) begin
                row = d[3:0] ^ {4{spr_attr[i][7]}};
                s   = c[3:0] ^ {4{spr_attr[i][6]}};
                a   = {spr_attr[i][5], spr_code[i], row, s[3]};
                n   = rom_nibble(a, s[2:0]);
                if (n != 4'd0) begin
                    res = {spr_attr[i][3:0], n};
                end
            end
        end
        return res;
    endfunction

    task automatic cpu_write(input logic [9:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        cpu_addr  = a;
        cpu_wdata = d;
        obj_cs    = 1'b1;
        cpu_rnw   = 1'b0;
        @(posedge clk);
        #1;
        obj_cs    = 1'b0;
        cpu_rnw   = 1'b1;
    endtask

    task automatic cpu_check(input string name, input logic [9:0] a, input logic [7:0] exp);
        @(posedge clk);
        #1;
        cpu_addr = a;
        obj_cs   = 1'b1;
        cpu_rnw  = 1'b1;
        @(posedge clk);
        #1;
        obj_cs = 1'b0;
        checks++;
        assert (obj_dout == exp) else begin
            $display("FAILED %s expected %h actual %h", name, exp, obj_dout);
            errors++;
        end
    endtask

    // 320 clocks per line, pixel enable on odd clocks so it never meets hinit
    always @(posedge clk) begin
        #1;
        if (video_on) begin
            if (!started) begin
                started = 1'b1;
                hcnt    = 9'd0;
                vdump   = 9'd0;
            end else if (hcnt == 9'd319) begin
                hcnt  = 9'd0;
                vdump = vdump + 9'd1;
            end else begin
                hcnt = hcnt + 9'd1;
            end
            hinit   = (hcnt == 9'd0);
            pxl_cen = hcnt[0];
            hdump   = {1'b0, hcnt[8:1]};
        end
    end

    // pxl is valid the clock after pxl_cen
    always @(posedge clk) begin
        chk_pxl <= pxl_cen && started && vdump >= 9'd2;
        chk_x   <= hdump[7:0];
        chk_v   <= vdump[7:0];
    end

    always @(negedge clk) begin
        if (chk_pxl) begin
            checks++;
            assert (pxl == expect_pxl(chk_v, chk_x - HOFF)) else begin
                $display("FAILED pixel line %0d x %0d expected %h actual %h", chk_v, chk_x,
                         expect_pxl(chk_v, chk_x - HOFF), pxl);
                errors++;
            end
        end
        // one scroll strobe per line
        if (hinit && started && vdump != 9'd0) begin
            checks++;
            assert (scr_cnt == 1) else begin
                $display("FAILED scroll strobe count expected 1 actual %0d", scr_cnt);
                errors++;
            end
            scr_cnt = 0;
        end
        if (scr_we && started) begin
            scr_cnt++;
            checks++;
            assert (hpos == scroll_hpos(vdump)) else begin
                $display("FAILED row scroll line %0d expected %h actual %h", vdump,
                         scroll_hpos(vdump), hpos);
                errors++;
            end
        end
    end

    // the drawer may only release req once the ROM has acked
    a_req_release: assert property (
        @(posedge clk) disable iff (rst) $fell(rom_req) |-> $past(rom_ack)
    ) else begin
        $display("ROM handshake broken, req dropped before ack was seen");
        errors++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, video did not reach the last line", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cpu_addr = '0;
        cpu_wdata = '0;
        obj_cs = 1'b0;
        cpu_rnw = 1'b1;
        frame = 1'b1;
        hinit = 1'b0;
        vdump = '0;
        hdump = '0;
        pxl_cen = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        scr_cnt = 0;
        video_on = 1'b0;
        started = 1'b0;
        hcnt = '0;
        // sprite set: attr (vflip, hflip, code msb, pal), y, code, x
        // entry 3 is the checkerboard sprite over entry 0
        spr_attr = '{8'h03, 8'h65, 8'h86, 8'h29, 8'hc2};
        spr_y    = '{8'd8, 8'd12, 8'd20, 8'd14, 8'd2};
        spr_code = '{8'h12, 8'h45, 8'h33, 8'haa, 8'hc7};
        spr_x    = '{8'd10, 8'd40, 8'd70, 8'd14, 8'd100};
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // bank isolation
        cpu_write(10'h3f0, 8'ha5);
        frame = 1'b0;
        cpu_write(10'h3f0, 8'h5c);
        cpu_check("readback bank 0", 10'h3f0, 8'h5c);

        for (int i = 0; i < 24; i++) begin
            if (i < NSPR) begin
                cpu_write(10'(i * 4),     spr_attr[i]);
                cpu_write(10'(i * 4 + 1), spr_y[i]);
                cpu_write(10'(i * 4 + 2), spr_code[i]);
                cpu_write(10'(i * 4 + 3), spr_x[i]);
            end else begin
                // parked far below the tested lines
                cpu_write(10'(i * 4),     8'h00);
                cpu_write(10'(i * 4 + 1), 8'hf0);
                cpu_write(10'(i * 4 + 2), 8'h00);
                cpu_write(10'(i * 4 + 3), 8'h00);
            end
        end
        for (int b = 0; b < 32; b++) begin
            cpu_write(SCROLL_BASE + 10'(b * 2),     scroll_byte(b, 0));
            cpu_write(SCROLL_BASE + 10'(b * 2 + 1), scroll_byte(b, 1));
        end
        cpu_check("readback entry 1 code", 10'd6, spr_code[1]);

        // scanner now reads bank 0
        frame = 1'b1;
        cpu_check("readback bank 1", 10'h3f0, 8'ha5);

        video_on = 1'b1;
        wait (vdump == 9'd30);
        @(posedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/obj_pkg.sv
rtl/obj_draw_if.sv
rtl/obj_table_ram.sv
rtl/obj_scan.sv
rtl/obj_draw.sv
rtl/obj_line_buf.sv
rtl/obj_top.sv
verification/obj_rom_model.sv
verification/obj_tb.sv

/* run.sh */
#!/bin/sh
# build and run the sprite subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module obj_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vobj_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
